//--- dx_width_pkg.sv
package dx_width_pkg;

	// Data path
	localparam int XLEN        = 32;
	localparam int ILEN        = 32;
	localparam int ADDR_W      = 32;

	// Register file index
	localparam int REG_INDEX_W = 5;

	// Memory access length codes
	localparam int WLEN_W      = 2;
	localparam int RLEN_W      = 3;

	// One data word, also used for CSR data
	typedef logic [XLEN-1:0]        xlen_t;

	// Raw instruction word
	typedef logic [ILEN-1:0]        instr_t;

	// Instruction address
	typedef logic [ADDR_W-1:0]      addr_t;

	// rs1, rs2 and rd
	typedef logic [REG_INDEX_W-1:0] reg_idx_t;

	// Store length: byte, half, word
	typedef logic [WLEN_W-1:0]      wlen_t;

	// Load length with sign bit
	typedef logic [RLEN_W-1:0]      rlen_t;

endpackage

//--- dx_ctrl_pkg.sv
package dx_ctrl_pkg;

	// Control word layout
	localparam int CTRL_W            = 6;
	localparam int CTRL_JALR_BIT     = 5;
	localparam int CTRL_LS_BIT       = 4;
	localparam int CTRL_SEL_RS2_BIT  = 3;
	localparam int CTRL_SEL_RS1_BIT  = 2;
	localparam int CTRL_FROM_ALU_BIT = 1;
	localparam int CTRL_WEN_BIT      = 0;

	typedef logic [CTRL_W-1:0] ctrl_sig_t;

	localparam ctrl_sig_t CTRL_RESET    = '0;
	localparam ctrl_sig_t CTRL_AUX_IDLE = ctrl_sig_t'(1) << CTRL_FROM_ALU_BIT; // Bubble, ALU source

	// Operation code
	localparam int OP_TYPE_W = 5;

	typedef logic [OP_TYPE_W-1:0] op_type_t;

	localparam op_type_t OP_NOP = '0;

	// One-hot instruction format, R in the top bit
	localparam int INSTR_TYPE_W = 6;
	localparam int RTYPE_BIT    = 5;
	localparam int ITYPE_BIT    = 4;
	localparam int STYPE_BIT    = 3;
	localparam int BTYPE_BIT    = 2;
	localparam int UTYPE_BIT    = 1;
	localparam int JTYPE_BIT    = 0;

	typedef logic [INSTR_TYPE_W-1:0] instr_type_t;

	localparam instr_type_t UKTYPE = '0; // Unknown format
	localparam instr_type_t RTYPE  = instr_type_t'(1) << RTYPE_BIT;
	localparam instr_type_t ITYPE  = instr_type_t'(1) << ITYPE_BIT;
	localparam instr_type_t STYPE  = instr_type_t'(1) << STYPE_BIT;
	localparam instr_type_t BTYPE  = instr_type_t'(1) << BTYPE_BIT;
	localparam instr_type_t UTYPE  = instr_type_t'(1) << UTYPE_BIT;
	localparam instr_type_t JTYPE  = instr_type_t'(1) << JTYPE_BIT;

	// Address loaded into the stage under reset
	localparam dx_width_pkg::addr_t PC_RESET_ADDR = 32'h0000_0000;

endpackage

//--- dx_main_lane.sv
`timescale 1ns/1ps

module dx_main_lane (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     hold,
	input  logic                     flush_dc,
	input  logic                     ci_for_branch_after_load,
	input  dx_ctrl_pkg::ctrl_sig_t   ctrl_sig_dc,
	input  dx_ctrl_pkg::op_type_t    op_type_dc,
	input  dx_ctrl_pkg::instr_type_t instr_type_dc,
	input  logic                     wdata_en_dc,
	input  dx_width_pkg::wlen_t      wlen_dc,
	input  dx_width_pkg::rlen_t      rlen_dc,
	input  dx_width_pkg::instr_t     instr_dc,
	input  dx_width_pkg::addr_t      instr_addr_dc,
	input  dx_width_pkg::xlen_t      reg_data0_dc,
	input  dx_width_pkg::xlen_t      reg_data1_dc,
	input  dx_width_pkg::xlen_t      sext_imm_dc,
	input  logic                     cancel_instr_dc,
	input  logic                     wcsr_en_dc,
	input  dx_width_pkg::reg_idx_t   rs1_dc,
	input  dx_width_pkg::reg_idx_t   rs2_dc,
	input  dx_width_pkg::reg_idx_t   rd_dc,
	input  logic                     is_branch_instr_dc,
	input  logic                     is_ecall_instr_dc,
	input  logic                     is_mret_instr_dc,
	input  logic                     is_fencei_dc,
	input  dx_width_pkg::xlen_t      csr_data_dc,
	output dx_ctrl_pkg::ctrl_sig_t   ctrl_sig_ex,
	output dx_ctrl_pkg::op_type_t    op_type_ex,
	output dx_ctrl_pkg::instr_type_t instr_type_ex,
	output logic                     wdata_en_ex,
	output dx_width_pkg::wlen_t      wlen_ex,
	output dx_width_pkg::rlen_t      rlen_ex,
	output dx_width_pkg::instr_t     instr_ex,
	output dx_width_pkg::addr_t      instr_addr_ex,
	output dx_width_pkg::xlen_t      reg_data0_ex,
	output dx_width_pkg::xlen_t      reg_data1_ex,
	output dx_width_pkg::xlen_t      sext_imm_ex,
	output logic                     cancel_instr_ex,
	output logic                     wcsr_en_ex,
	output dx_width_pkg::reg_idx_t   rs1_ex,
	output dx_width_pkg::reg_idx_t   rs2_ex,
	output dx_width_pkg::reg_idx_t   rd_ex,
	output logic                     is_branch_instr_ex,
	output logic                     is_ecall_instr_ex,
	output logic                     is_mret_instr_ex,
	output logic                     is_fencei_ex,
	output dx_width_pkg::xlen_t      csr_data_ex
);

	logic                   drop_wen;    // No register write for this slot
	logic                   drop_wdata;  // No store data for this slot
	logic                   force_cancel;
	dx_ctrl_pkg::ctrl_sig_t ctrl_sig_nxt;

	assign drop_wen     = cancel_instr_dc | ci_for_branch_after_load;
	assign drop_wdata   = drop_wen | flush_dc;
	assign force_cancel = ci_for_branch_after_load | flush_dc;

	always_comb begin
		ctrl_sig_nxt = ctrl_sig_dc;
		if (drop_wen) begin
			ctrl_sig_nxt[dx_ctrl_pkg::CTRL_WEN_BIT] = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctrl_sig_ex        <= dx_ctrl_pkg::CTRL_RESET;
			op_type_ex         <= dx_ctrl_pkg::OP_NOP;
			instr_type_ex      <= dx_ctrl_pkg::UKTYPE;
			wdata_en_ex        <= 1'b0;
			wlen_ex            <= '0;
			rlen_ex            <= '0;
			instr_ex           <= '0;
			instr_addr_ex      <= dx_ctrl_pkg::PC_RESET_ADDR;
			reg_data0_ex       <= '0;
			reg_data1_ex       <= '0;
			sext_imm_ex        <= '0;
			cancel_instr_ex    <= 1'b1; // Empty slot after reset
			wcsr_en_ex         <= 1'b0;
			rs1_ex             <= '0;
			rs2_ex             <= '0;
			rd_ex              <= '0;
			is_branch_instr_ex <= 1'b0;
			is_ecall_instr_ex  <= 1'b0;
			is_mret_instr_ex   <= 1'b0;
			is_fencei_ex       <= 1'b0;
			csr_data_ex        <= '0;
		end else if (!hold) begin
			ctrl_sig_ex        <= ctrl_sig_nxt;
			op_type_ex         <= op_type_dc;
			instr_type_ex      <= instr_type_dc;
			wdata_en_ex        <= wdata_en_dc & ~drop_wdata;
			wlen_ex            <= wlen_dc;
			rlen_ex            <= rlen_dc;
			instr_ex           <= instr_dc;
			instr_addr_ex      <= instr_addr_dc;
			reg_data0_ex       <= reg_data0_dc;
			reg_data1_ex       <= reg_data1_dc;
			sext_imm_ex        <= sext_imm_dc;
			cancel_instr_ex    <= cancel_instr_dc | force_cancel;
			wcsr_en_ex         <= wcsr_en_dc;
			rs1_ex             <= rs1_dc;
			rs2_ex             <= rs2_dc;
			rd_ex              <= rd_dc;
			is_branch_instr_ex <= is_branch_instr_dc;
			is_ecall_instr_ex  <= is_ecall_instr_dc;
			is_mret_instr_ex   <= is_mret_instr_dc;
			is_fencei_ex       <= is_fencei_dc;
			csr_data_ex        <= csr_data_dc;
		end
	end

endmodule

//--- dx_aux_lane.sv
`timescale 1ns/1ps

module dx_aux_lane (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     hold,
	input  logic                     flush_dc,
	input  logic                     ci_for_branch_after_load,
	input  dx_ctrl_pkg::ctrl_sig_t   ctrl_sig_dc,
	input  dx_ctrl_pkg::instr_type_t instr_type_dc,
	input  logic                     aux_can_issue_dc_aux,
	input  logic                     cancel_instr_dc_aux,
	input  dx_ctrl_pkg::ctrl_sig_t   ctrl_sig_dc_aux,
	input  dx_ctrl_pkg::op_type_t    op_type_dc_aux,
	input  dx_ctrl_pkg::instr_type_t instr_type_dc_aux,
	input  dx_width_pkg::reg_idx_t   rs1_dc_aux,
	input  dx_width_pkg::reg_idx_t   rs2_dc_aux,
	input  dx_width_pkg::reg_idx_t   rd_dc_aux,
	input  dx_width_pkg::xlen_t      op0_dc_aux,
	input  dx_width_pkg::xlen_t      op1_dc_aux,
	output dx_ctrl_pkg::ctrl_sig_t   ctrl_sig_ex_aux,
	output dx_ctrl_pkg::op_type_t    op_type_ex_aux,
	output dx_ctrl_pkg::instr_type_t instr_type_ex_aux,
	output dx_width_pkg::reg_idx_t   rs1_ex_aux,
	output dx_width_pkg::reg_idx_t   rs2_ex_aux,
	output dx_width_pkg::reg_idx_t   rd_ex_aux,
	output dx_width_pkg::xlen_t      op0_ex_aux,
	output dx_width_pkg::xlen_t      op1_ex_aux,
	output logic                     cancel_instr_ex_aux
);

	logic main_redirect; // Main slot jumps, so the aux slot is off-path
	logic kill;

	// A taken jal or jalr in the main lane makes the paired aux instruction dead
	assign main_redirect = ctrl_sig_dc[dx_ctrl_pkg::CTRL_JALR_BIT]
		| instr_type_dc[dx_ctrl_pkg::JTYPE_BIT];

	assign kill = ~aux_can_issue_dc_aux
		| main_redirect
		| flush_dc
		| cancel_instr_dc_aux
		| ci_for_branch_after_load;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctrl_sig_ex_aux     <= dx_ctrl_pkg::CTRL_RESET;
			op_type_ex_aux      <= dx_ctrl_pkg::OP_NOP;
			instr_type_ex_aux   <= dx_ctrl_pkg::UKTYPE;
			rs1_ex_aux          <= '0;
			rs2_ex_aux          <= '0;
			rd_ex_aux           <= '0;
			op0_ex_aux          <= '0;
			op1_ex_aux          <= '0;
			cancel_instr_ex_aux <= 1'b1;
		end else if (!hold) begin
			ctrl_sig_ex_aux     <= kill ? dx_ctrl_pkg::CTRL_AUX_IDLE : ctrl_sig_dc_aux;
			op_type_ex_aux      <= op_type_dc_aux;
			instr_type_ex_aux   <= instr_type_dc_aux;
			rs1_ex_aux          <= rs1_dc_aux;
			rs2_ex_aux          <= rs2_dc_aux;
			rd_ex_aux           <= rd_dc_aux;
			op0_ex_aux          <= op0_dc_aux; // Operands pass even when killed
			op1_ex_aux          <= op1_dc_aux;
			cancel_instr_ex_aux <= kill;
		end
	end

endmodule

//--- decode_execute.sv
`timescale 1ns/1ps

module decode_execute (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     hold,
	input  logic                     flush_dc,
	input  logic                     ci_for_branch_after_load,

	// Main lane from decode
	input  dx_ctrl_pkg::ctrl_sig_t   ctrl_sig_dc,
	input  dx_ctrl_pkg::op_type_t    op_type_dc,
	input  dx_ctrl_pkg::instr_type_t instr_type_dc,
	input  logic                     wdata_en_dc,
	input  dx_width_pkg::wlen_t      wlen_dc,
	input  dx_width_pkg::rlen_t      rlen_dc,
	input  dx_width_pkg::instr_t     instr_dc,
	input  dx_width_pkg::addr_t      instr_addr_dc,
	input  dx_width_pkg::xlen_t      reg_data0_dc,
	input  dx_width_pkg::xlen_t      reg_data1_dc,
	input  dx_width_pkg::xlen_t      sext_imm_dc,
	input  logic                     cancel_instr_dc,
	input  logic                     wcsr_en_dc,
	input  dx_width_pkg::reg_idx_t   rs1_dc,
	input  dx_width_pkg::reg_idx_t   rs2_dc,
	input  dx_width_pkg::reg_idx_t   rd_dc,
	input  logic                     is_branch_instr_dc,
	input  logic                     is_ecall_instr_dc,
	input  logic                     is_mret_instr_dc,
	input  logic                     is_fencei_dc,
	input  dx_width_pkg::xlen_t      csr_data_dc,

	// Aux lane from decode
	input  logic                     aux_can_issue_dc_aux,
	input  logic                     cancel_instr_dc_aux,
	input  dx_ctrl_pkg::ctrl_sig_t   ctrl_sig_dc_aux,
	input  dx_ctrl_pkg::op_type_t    op_type_dc_aux,
	input  dx_ctrl_pkg::instr_type_t instr_type_dc_aux,
	input  dx_width_pkg::reg_idx_t   rs1_dc_aux,
	input  dx_width_pkg::reg_idx_t   rs2_dc_aux,
	input  dx_width_pkg::reg_idx_t   rd_dc_aux,
	input  dx_width_pkg::xlen_t      op0_dc_aux,
	input  dx_width_pkg::xlen_t      op1_dc_aux,

	// Main lane to execute
	output dx_ctrl_pkg::ctrl_sig_t   ctrl_sig_ex,
	output dx_ctrl_pkg::op_type_t    op_type_ex,
	output dx_ctrl_pkg::instr_type_t instr_type_ex,
	output logic                     wdata_en_ex,
	output dx_width_pkg::wlen_t      wlen_ex,
	output dx_width_pkg::rlen_t      rlen_ex,
	output dx_width_pkg::instr_t     instr_ex,
	output dx_width_pkg::addr_t      instr_addr_ex,
	output dx_width_pkg::xlen_t      reg_data0_ex,
	output dx_width_pkg::xlen_t      reg_data1_ex,
	output dx_width_pkg::xlen_t      sext_imm_ex,
	output logic                     cancel_instr_ex,
	output logic                     wcsr_en_ex,
	output dx_width_pkg::reg_idx_t   rs1_ex,
	output dx_width_pkg::reg_idx_t   rs2_ex,
	output dx_width_pkg::reg_idx_t   rd_ex,
	output logic                     is_branch_instr_ex,
	output logic                     is_ecall_instr_ex,
	output logic                     is_mret_instr_ex,
	output logic                     is_fencei_ex,
	output dx_width_pkg::xlen_t      csr_data_ex,

	// Aux lane to execute
	output dx_ctrl_pkg::ctrl_sig_t   ctrl_sig_ex_aux,
	output dx_ctrl_pkg::op_type_t    op_type_ex_aux,
	output dx_ctrl_pkg::instr_type_t instr_type_ex_aux,
	output dx_width_pkg::reg_idx_t   rs1_ex_aux,
	output dx_width_pkg::reg_idx_t   rs2_ex_aux,
	output dx_width_pkg::reg_idx_t   rd_ex_aux,
	output dx_width_pkg::xlen_t      op0_ex_aux,
	output dx_width_pkg::xlen_t      op1_ex_aux,
	output logic                     cancel_instr_ex_aux
);

	// Port names match one to one, so both lanes bind by name
	dx_main_lane main_lane_i (
		.*
	);

	// Also sees ctrl_sig_dc and instr_type_dc of the main slot
	dx_aux_lane aux_lane_i (
		.*
	);

endmodule

//--- tb_decode_execute.sv
`timescale 1ns/1ps

module tb_decode_execute;

	localparam int RESET_CYCLES = 10;
	localparam int RUN_CYCLES   = 2000;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + 2200;

	typedef struct packed {
		dx_ctrl_pkg::ctrl_sig_t   ctrl_sig;
		dx_ctrl_pkg::op_type_t    op_type;
		dx_ctrl_pkg::instr_type_t instr_type;
		logic                     wdata_en;
		dx_width_pkg::wlen_t      wlen;
		dx_width_pkg::rlen_t      rlen;
		dx_width_pkg::instr_t     instr;
		dx_width_pkg::addr_t      instr_addr;
		dx_width_pkg::xlen_t      reg_data0;
		dx_width_pkg::xlen_t      reg_data1;
		dx_width_pkg::xlen_t      sext_imm;
		logic                     cancel;
		logic                     wcsr_en;
		dx_width_pkg::reg_idx_t   rs1;
		dx_width_pkg::reg_idx_t   rs2;
		dx_width_pkg::reg_idx_t   rd;
		logic                     is_branch;
		logic                     is_ecall;
		logic                     is_mret;
		logic                     is_fencei;
		dx_width_pkg::xlen_t      csr_data;
		dx_ctrl_pkg::ctrl_sig_t   ctrl_aux;
		dx_ctrl_pkg::op_type_t    op_type_aux;
		dx_ctrl_pkg::instr_type_t instr_type_aux;
		dx_width_pkg::reg_idx_t   rs1_aux;
		dx_width_pkg::reg_idx_t   rs2_aux;
		dx_width_pkg::reg_idx_t   rd_aux;
		dx_width_pkg::xlen_t      op0_aux;
		dx_width_pkg::xlen_t      op1_aux;
		logic                     cancel_aux;
	} lanes_t; // Same layout for decode inputs and execute outputs

	logic        clk;
	logic        rst_n;
	logic        hold;
	logic        flush_dc;
	logic        ci_bal;
	logic        aux_can_issue;
	lanes_t      din;
	lanes_t      dout;
	lanes_t      exp_st;
	logic [31:0] lfsr;
	int          errors;
	int          cycles;
	logic        checking;

	always #10 clk = ~clk;

	decode_execute decode_execute_i (
		.clk(clk), .rst_n(rst_n), .hold(hold), .flush_dc(flush_dc),
		.ci_for_branch_after_load(ci_bal),
		.ctrl_sig_dc(din.ctrl_sig), .op_type_dc(din.op_type), .instr_type_dc(din.instr_type),
		.wdata_en_dc(din.wdata_en), .wlen_dc(din.wlen), .rlen_dc(din.rlen),
		.instr_dc(din.instr), .instr_addr_dc(din.instr_addr),
		.reg_data0_dc(din.reg_data0), .reg_data1_dc(din.reg_data1), .sext_imm_dc(din.sext_imm),
		.cancel_instr_dc(din.cancel), .wcsr_en_dc(din.wcsr_en),
		.rs1_dc(din.rs1), .rs2_dc(din.rs2), .rd_dc(din.rd),
		.is_branch_instr_dc(din.is_branch), .is_ecall_instr_dc(din.is_ecall),
		.is_mret_instr_dc(din.is_mret), .is_fencei_dc(din.is_fencei), .csr_data_dc(din.csr_data),
		.aux_can_issue_dc_aux(aux_can_issue), .cancel_instr_dc_aux(din.cancel_aux),
		.ctrl_sig_dc_aux(din.ctrl_aux), .op_type_dc_aux(din.op_type_aux),
		.instr_type_dc_aux(din.instr_type_aux),
		.rs1_dc_aux(din.rs1_aux), .rs2_dc_aux(din.rs2_aux), .rd_dc_aux(din.rd_aux),
		.op0_dc_aux(din.op0_aux), .op1_dc_aux(din.op1_aux),
		.ctrl_sig_ex(dout.ctrl_sig), .op_type_ex(dout.op_type), .instr_type_ex(dout.instr_type),
		.wdata_en_ex(dout.wdata_en), .wlen_ex(dout.wlen), .rlen_ex(dout.rlen),
		.instr_ex(dout.instr), .instr_addr_ex(dout.instr_addr),
		.reg_data0_ex(dout.reg_data0), .reg_data1_ex(dout.reg_data1),
		.sext_imm_ex(dout.sext_imm), .cancel_instr_ex(dout.cancel), .wcsr_en_ex(dout.wcsr_en),
		.rs1_ex(dout.rs1), .rs2_ex(dout.rs2), .rd_ex(dout.rd),
		.is_branch_instr_ex(dout.is_branch), .is_ecall_instr_ex(dout.is_ecall),
		.is_mret_instr_ex(dout.is_mret), .is_fencei_ex(dout.is_fencei),
		.csr_data_ex(dout.csr_data),
		.ctrl_sig_ex_aux(dout.ctrl_aux), .op_type_ex_aux(dout.op_type_aux),
		.instr_type_ex_aux(dout.instr_type_aux),
		.rs1_ex_aux(dout.rs1_aux), .rs2_ex_aux(dout.rs2_aux), .rd_ex_aux(dout.rd_aux),
		.op0_ex_aux(dout.op0_aux), .op1_ex_aux(dout.op1_aux),
		.cancel_instr_ex_aux(dout.cancel_aux)
	);

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic one_in_eight();
		return rand_bits(3) == 32'd0;
	endfunction

	// Expected stage contents after one clock edge
	function automatic lanes_t next_expected(lanes_t prev, lanes_t in, logic rstn, logic hld,
		logic flush, logic cibl, logic can_issue);
		lanes_t n;
		logic   kill;
		if (!rstn) begin
			n            = '0;
			n.ctrl_sig   = dx_ctrl_pkg::CTRL_RESET;
			n.op_type    = dx_ctrl_pkg::OP_NOP;
			n.instr_type = dx_ctrl_pkg::UKTYPE;
			n.instr_addr = dx_ctrl_pkg::PC_RESET_ADDR;
			n.cancel     = 1'b1;
			n.ctrl_aux   = dx_ctrl_pkg::CTRL_RESET;
			n.op_type_aux    = dx_ctrl_pkg::OP_NOP;
			n.instr_type_aux = dx_ctrl_pkg::UKTYPE;
			n.cancel_aux = 1'b1;
			return n;
		end
		if (hld) begin
			return prev;
		end
		n = in;
		if (in.cancel || cibl) begin
			n.ctrl_sig[dx_ctrl_pkg::CTRL_WEN_BIT] = 1'b0;
		end
		if (in.cancel || cibl || flush) begin
			n.wdata_en = 1'b0;
		end
		n.cancel = in.cancel | cibl | flush;
		kill = !can_issue || in.ctrl_sig[dx_ctrl_pkg::CTRL_JALR_BIT]
			|| in.instr_type[dx_ctrl_pkg::JTYPE_BIT] || flush || in.cancel_aux || cibl;
		n.ctrl_aux   = kill ? dx_ctrl_pkg::CTRL_AUX_IDLE : in.ctrl_aux;
		n.cancel_aux = kill;
		return n;
	endfunction

	function automatic lanes_t random_inputs();
		lanes_t r;
		r = lanes_t'({rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32),
			rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32),
			rand_bits(32), 13'(rand_bits(13))});
		r.ctrl_sig[dx_ctrl_pkg::CTRL_JALR_BIT] = one_in_eight();
		r.instr_type[dx_ctrl_pkg::JTYPE_BIT]   = one_in_eight();
		r.cancel     = one_in_eight();
		r.cancel_aux = one_in_eight();
		return r;
	endfunction

	task automatic check_field(string name, logic [31:0] got, logic [31:0] want);
		if (got !== want) begin
			$display("mismatch %s got %h expected %h at %0t", name, got, want, $time);
			errors++;
		end
	endtask

	always @(posedge clk) begin
		exp_st <= next_expected(exp_st, din, rst_n, hold, flush_dc, ci_bal, aux_can_issue);
		checking <= 1'b1;
	end

	// Outputs are stable mid-cycle
	always @(negedge clk) begin
		if (checking) begin
			check_field("ctrl_sig_ex", 32'(dout.ctrl_sig), 32'(exp_st.ctrl_sig));
			check_field("op_type_ex", 32'(dout.op_type), 32'(exp_st.op_type));
			check_field("instr_type_ex", 32'(dout.instr_type), 32'(exp_st.instr_type));
			check_field("wdata_en_ex", 32'(dout.wdata_en), 32'(exp_st.wdata_en));
			check_field("wlen_ex", 32'(dout.wlen), 32'(exp_st.wlen));
			check_field("rlen_ex", 32'(dout.rlen), 32'(exp_st.rlen));
			check_field("instr_ex", dout.instr, exp_st.instr);
			check_field("instr_addr_ex", dout.instr_addr, exp_st.instr_addr);
			check_field("reg_data0_ex", dout.reg_data0, exp_st.reg_data0);
			check_field("reg_data1_ex", dout.reg_data1, exp_st.reg_data1);
			check_field("sext_imm_ex", dout.sext_imm, exp_st.sext_imm);
			check_field("cancel_instr_ex", 32'(dout.cancel), 32'(exp_st.cancel));
			check_field("wcsr_en_ex", 32'(dout.wcsr_en), 32'(exp_st.wcsr_en));
			check_field("rs1_ex", 32'(dout.rs1), 32'(exp_st.rs1));
			check_field("rs2_ex", 32'(dout.rs2), 32'(exp_st.rs2));
			check_field("rd_ex", 32'(dout.rd), 32'(exp_st.rd));
			check_field("is_branch_instr_ex", 32'(dout.is_branch), 32'(exp_st.is_branch));
			check_field("is_ecall_instr_ex", 32'(dout.is_ecall), 32'(exp_st.is_ecall));
			check_field("is_mret_instr_ex", 32'(dout.is_mret), 32'(exp_st.is_mret));
			check_field("is_fencei_ex", 32'(dout.is_fencei), 32'(exp_st.is_fencei));
			check_field("csr_data_ex", dout.csr_data, exp_st.csr_data);
			check_field("ctrl_sig_ex_aux", 32'(dout.ctrl_aux), 32'(exp_st.ctrl_aux));
			check_field("op_type_ex_aux", 32'(dout.op_type_aux), 32'(exp_st.op_type_aux));
			check_field("instr_type_ex_aux", 32'(dout.instr_type_aux),
				32'(exp_st.instr_type_aux));
			check_field("rs1_ex_aux", 32'(dout.rs1_aux), 32'(exp_st.rs1_aux));
			check_field("rs2_ex_aux", 32'(dout.rs2_aux), 32'(exp_st.rs2_aux));
			check_field("rd_ex_aux", 32'(dout.rd_aux), 32'(exp_st.rd_aux));
			check_field("op0_ex_aux", dout.op0_aux, exp_st.op0_aux);
			check_field("op1_ex_aux", dout.op1_aux, exp_st.op1_aux);
			check_field("cancel_instr_ex_aux", 32'(dout.cancel_aux), 32'(exp_st.cancel_aux));
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, run did not finish", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		hold = 1'b0;
		flush_dc = 1'b0;
		ci_bal = 1'b0;
		aux_can_issue = 1'b0;
		din = '0;
		exp_st = '0;
		lfsr = 32'h90de75df;
		errors = 0;
		cycles = 0;
		checking = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < RUN_CYCLES; i++) begin
			@(posedge clk);
			din           <= random_inputs();
			flush_dc      <= one_in_eight();
			ci_bal        <= one_in_eight();
			aux_can_issue <= !one_in_eight();
			hold          <= rand_bits(2) == 32'd0; // About one cycle in four
			if (i >= 1000 && i < 1003) begin
				rst_n <= 1'b0; // Reset during hold
				hold  <= 1'b1;
			end else begin
				rst_n <= 1'b1;
			end
		end
		@(posedge clk);
		@(negedge clk);
		$display("run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- filelist.f
dx_width_pkg.sv
dx_ctrl_pkg.sv
dx_main_lane.sv
dx_aux_lane.sv
decode_execute.sv
tb_decode_execute.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the decode/execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f filelist.f --top-module tb_decode_execute -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi

if ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0
